// File: Makefile
SIM     := verilator
TOP     := tb_lcd_ctrl
FLIST   := lcd_ctrl.f
VFLAGS  := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: lcd_axil_slave.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one outstanding request per direction
// responses are always OKAY, no wstrb or prot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lcd_axil_slave (
  input  logic                    aclk,
  input  logic                    arstn,
  input  lcd_bus_pkg::reg_addr_t  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  lcd_bus_pkg::axil_data_t wdata,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  lcd_bus_pkg::reg_addr_t  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output lcd_bus_pkg::axil_data_t rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    reg_wr_en,
  output lcd_bus_pkg::reg_addr_t  reg_wr_addr,
  output lcd_bus_pkg::axil_data_t reg_wr_data,
  input  logic                    reg_wr_ack,
  output logic                    reg_rd_en,
  output lcd_bus_pkg::reg_addr_t  reg_rd_addr,
  input  lcd_bus_pkg::axil_data_t reg_rd_data,
  input  logic                    reg_rd_ack
);
  import lcd_bus_pkg::*;

  logic aw_held;
  logic w_held;
  logic ar_held;

  assign reg_wr_en = aw_held & w_held;  // both channels in hand
  assign reg_rd_en = ar_held;
  assign bresp     = axi_resp_okay;
  assign rresp     = axi_resp_okay;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      ar_held <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= ~awready & awvalid & ~aw_held & ~bvalid;  // one-cycle pulse
      wready  <= ~wready & wvalid & ~w_held & ~bvalid;
      arready <= ~arready & arvalid & ~ar_held & ~rvalid;
      if (awvalid && awready) aw_held <= 1'b1;
      if (wvalid && wready) w_held <= 1'b1;
      if (arvalid && arready) ar_held <= 1'b1;
      if (reg_wr_ack) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (reg_rd_ack) begin
        ar_held <= 1'b0;
        rvalid  <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (awvalid && awready) reg_wr_addr <= awaddr;
    if (wvalid && wready) reg_wr_data <= wdata;
    if (arvalid && arready) reg_rd_addr <= araddr;
    if (reg_rd_ack) rdata <= reg_rd_data;  // data valid in ack cycle
  end

  bvalid_held_a: assert property (@(posedge aclk) disable iff (!arstn)
    bvalid && !bready |=> bvalid);

endmodule

// File: lcd_bus_engine.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// window requests go before the command FIFO
// write_n_param sends low half first, at least one beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lcd_bus_engine (
  input  logic                     aclk,
  input  logic                     arstn,
  input  lcd_bus_pkg::timing_cfg_t timing,
  input  logic                     win_wr_req,
  input  logic                     win_rd_req,
  input  lcd_bus_pkg::axil_data_t  win_wr_data,
  output logic                     win_ack,
  output lcd_bus_pkg::bus_word_t   win_rd_data,
  input  lcd_bus_pkg::cmd_word_t   cmd_word,
  input  logic                     cmd_empty,
  output logic                     cmd_pop,
  input  lcd_bus_pkg::axil_data_t  data_word,
  input  logic                     data_empty,
  output logic                     data_pop,
  output logic                     dc,
  output logic                     wr_n,
  output logic                     rd_n,
  output logic                     oe,
  output lcd_bus_pkg::bus_word_t   dout,
  input  lcd_bus_pkg::bus_word_t   din
);
  import lcd_bus_pkg::*;

  typedef enum logic [2:0] {idle, wr_low, wr_high, rd_low, rd_high, wait_data} state_t;

  state_t      state;
  logic [7:0]  cnt;
  logic [23:0] bytes_left;
  logic        hi_half;    // high half of word on the bus
  bus_word_t   word_hi;
  logic        win_cycle;  // cycle started from window
  logic        more;
  logic        wr_low_end;
  logic        wr_high_end;
  logic        rd_low_end;
  logic        rd_high_end;

  assign wr_low_end  = (state == wr_low) && (cnt == timing.wr_low_len);
  assign wr_high_end = (state == wr_high) && (cnt == timing.wr_high_len);
  assign rd_low_end  = (state == rd_low) && (cnt == timing.rd_low_len);
  assign rd_high_end = (state == rd_high) && (cnt == timing.rd_high_len);
  assign more        = (bytes_left > 24'd2);
  assign win_ack     = win_cycle && (wr_high_end || rd_high_end);
  assign cmd_pop     = (state == idle) && !win_wr_req && !win_rd_req && !cmd_empty;
  assign data_pop    = (state == wait_data) && !data_empty;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      state      <= idle;
      cnt        <= '0;
      bytes_left <= '0;
      hi_half    <= 1'b0;
      win_cycle  <= 1'b0;
      wr_n       <= 1'b1;
      rd_n       <= 1'b1;
      oe         <= 1'b0;
      dc         <= 1'b1;
    end else begin
      cnt <= cnt + 8'd1;
      case (state)
        idle: begin
          cnt        <= '0;
          bytes_left <= '0;
          win_cycle  <= win_wr_req | win_rd_req;
          if (win_wr_req) begin
            state <= wr_low;
            wr_n  <= 1'b0;
            oe    <= 1'b1;
            dc    <= win_wr_data[31];
          end else if (win_rd_req) begin
            state <= rd_low;
            rd_n  <= 1'b0;
          end else if (cmd_pop) begin
            case (cmd_word.op)
              op_write_cmd, op_write_param: begin
                state <= wr_low;
                wr_n  <= 1'b0;
                oe    <= 1'b1;
                dc    <= (cmd_word.op == op_write_param);
              end
              op_write_n_param: begin
                state      <= wait_data;
                bytes_left <= cmd_word.arg;
              end
              op_reserved: state <= idle;  // popped and dropped
              default:     state <= idle;
            endcase
          end
        end
        wait_data: begin
          cnt <= '0;
          if (data_pop) begin
            state   <= wr_low;
            wr_n    <= 1'b0;
            oe      <= 1'b1;
            dc      <= 1'b1;
            hi_half <= 1'b0;
          end
        end
        wr_low: begin
          if (wr_low_end) begin
            state <= wr_high;
            wr_n  <= 1'b1;
            cnt   <= '0;
          end
        end
        wr_high: begin
          if (wr_high_end) begin
            cnt <= '0;
            if (more) begin
              bytes_left <= bytes_left - 24'd2;
              if (hi_half) begin
                state <= wait_data;  // word used up
                oe    <= 1'b0;
              end else begin
                state   <= wr_low;
                wr_n    <= 1'b0;
                hi_half <= 1'b1;
              end
            end else begin
              state <= idle;
              oe    <= 1'b0;
              dc    <= 1'b1;
            end
          end
        end
        rd_low: begin
          if (rd_low_end) begin
            state <= rd_high;
            rd_n  <= 1'b1;
            cnt   <= '0;
          end
        end
        rd_high: begin
          if (rd_high_end) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == idle && win_wr_req) begin
      dout <= win_wr_data[15:0];
    end else if (cmd_pop) begin
      dout <= cmd_word.arg[15:0];
    end else if (data_pop) begin
      dout    <= data_word[15:0];
      word_hi <= data_word[31:16];
    end else if (wr_high_end && more && !hi_half) begin
      dout <= word_hi;
    end
    if (rd_low_end) win_rd_data <= din;  // last low cycle
  end

  strobe_excl_a: assert property (@(posedge aclk) disable iff (!arstn) wr_n || rd_n);

endmodule

// File: lcd_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-bit display bus only, offsets are byte offsets
// every timing length holds cycles minus one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lcd_bus_pkg;

  typedef logic [31:0] axil_data_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [15:0] bus_word_t;

  localparam reg_addr_t reg_version   = 8'h00;
  localparam reg_addr_t reg_timing    = 8'h04;
  localparam reg_addr_t reg_control   = 8'h08;  // bit 4 drives rst_n
  localparam reg_addr_t reg_window    = 8'h0C;
  localparam reg_addr_t reg_cmd_fifo  = 8'h10;
  localparam reg_addr_t reg_data_fifo = 8'h14;
  localparam reg_addr_t reg_csn       = 8'h18;
  localparam reg_addr_t reg_status    = 8'h1C;

  localparam axil_data_t version_value = 32'h8080_0116;
  localparam logic [1:0] axi_resp_okay = 2'b00;

  typedef enum logic [1:0] {
    op_write_cmd     = 2'd0,
    op_write_param   = 2'd1,
    op_write_n_param = 2'd2,
    op_reserved      = 2'd3
  } cmd_op_t;

  typedef struct packed {
    cmd_op_t     op;
    logic [5:0]  unused;
    logic [23:0] arg;  // byte count, or beat value in [15:0]
  } cmd_word_t;

  typedef struct packed {
    logic [7:0] rd_high_len;  // [31:24]
    logic [7:0] rd_low_len;
    logic [7:0] wr_high_len;
    logic [7:0] wr_low_len;   // [7:0]
  } timing_cfg_t;

endpackage

// File: lcd_ctrl.f
lcd_bus_pkg.sv
lcd_fifo.sv
lcd_axil_slave.sv
lcd_regs.sv
lcd_bus_engine.sv
lcd_ctrl_top.sv
tb_lcd_ctrl.sv

// File: lcd_ctrl_top.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// both FIFOs hold 2**fifo_addr_bits words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lcd_ctrl_top #(
  parameter int fifo_addr_bits = 2
) (
  input  logic                    aclk,
  input  logic                    arstn,
  input  lcd_bus_pkg::reg_addr_t  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  lcd_bus_pkg::axil_data_t wdata,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  lcd_bus_pkg::reg_addr_t  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output lcd_bus_pkg::axil_data_t rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    rst_n,
  output logic                    cs_n,
  output logic                    dc,
  output logic                    wr_n,
  output logic                    rd_n,
  output logic                    oe,
  output lcd_bus_pkg::bus_word_t  dout,
  input  lcd_bus_pkg::bus_word_t  din
);
  import lcd_bus_pkg::*;

  logic        reg_wr_en;
  reg_addr_t   reg_wr_addr;
  axil_data_t  reg_wr_data;
  logic        reg_wr_ack;
  logic        reg_rd_en;
  reg_addr_t   reg_rd_addr;
  axil_data_t  reg_rd_data;
  logic        reg_rd_ack;
  logic        cmd_full;
  logic        cmd_empty;
  logic        cmd_push;
  logic        cmd_pop;
  cmd_word_t   cmd_word;
  logic        data_full;
  logic        data_empty;
  logic        data_push;
  logic        data_pop;
  axil_data_t  data_word;
  logic        win_wr_req;
  logic        win_rd_req;
  logic        win_ack;
  bus_word_t   win_rd_data;
  timing_cfg_t timing;

  lcd_axil_slave i_lcd_axil_slave (
    .aclk(aclk), .arstn(arstn),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .reg_wr_en(reg_wr_en), .reg_wr_addr(reg_wr_addr),
    .reg_wr_data(reg_wr_data), .reg_wr_ack(reg_wr_ack),
    .reg_rd_en(reg_rd_en), .reg_rd_addr(reg_rd_addr),
    .reg_rd_data(reg_rd_data), .reg_rd_ack(reg_rd_ack)
  );

  lcd_regs i_lcd_regs (
    .aclk(aclk), .arstn(arstn),
    .reg_wr_en(reg_wr_en), .reg_wr_addr(reg_wr_addr),
    .reg_wr_data(reg_wr_data), .reg_wr_ack(reg_wr_ack),
    .reg_rd_en(reg_rd_en), .reg_rd_addr(reg_rd_addr),
    .reg_rd_data(reg_rd_data), .reg_rd_ack(reg_rd_ack),
    .cmd_full(cmd_full), .data_full(data_full),
    .cmd_empty(cmd_empty), .data_empty(data_empty),
    .cmd_push(cmd_push), .data_push(data_push),
    .win_wr_req(win_wr_req), .win_rd_req(win_rd_req),
    .win_ack(win_ack), .win_rd_data(win_rd_data),
    .timing(timing), .rst_n(rst_n), .cs_n(cs_n)
  );

  lcd_fifo #(.payload_t(cmd_word_t), .fifo_addr_bits(fifo_addr_bits)) cmd_fifo (
    .aclk(aclk), .arstn(arstn),
    .din(cmd_word_t'(reg_wr_data)), .push(cmd_push), .full(cmd_full),
    .dout(cmd_word), .pop(cmd_pop), .empty(cmd_empty)
  );

  lcd_fifo #(.payload_t(axil_data_t), .fifo_addr_bits(fifo_addr_bits)) data_fifo (
    .aclk(aclk), .arstn(arstn),
    .din(reg_wr_data), .push(data_push), .full(data_full),
    .dout(data_word), .pop(data_pop), .empty(data_empty)
  );

  lcd_bus_engine i_lcd_bus_engine (
    .aclk(aclk), .arstn(arstn), .timing(timing),
    .win_wr_req(win_wr_req), .win_rd_req(win_rd_req),
    .win_wr_data(reg_wr_data), .win_ack(win_ack), .win_rd_data(win_rd_data),
    .cmd_word(cmd_word), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
    .data_word(data_word), .data_empty(data_empty), .data_pop(data_pop),
    .dc(dc), .wr_n(wr_n), .rd_n(rd_n), .oe(oe), .dout(dout), .din(din)
  );

endmodule

// File: lcd_fifo.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through read, dout valid while not empty
// fifo_addr_bits must be at least 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lcd_fifo #(
  parameter type payload_t      = logic [31:0],
  parameter int  fifo_addr_bits = 2
) (
  input  logic     aclk,
  input  logic     arstn,
  input  payload_t din,
  input  logic     push,
  output logic     full,
  output payload_t dout,
  input  logic     pop,
  output logic     empty
);

  localparam int depth = 2 ** fifo_addr_bits;

  payload_t                mem [depth];
  logic [fifo_addr_bits:0] wr_ptr;  // extra wrap bit
  logic [fifo_addr_bits:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[fifo_addr_bits] != rd_ptr[fifo_addr_bits]) &&
                 (wr_ptr[fifo_addr_bits-1:0] == rd_ptr[fifo_addr_bits-1:0]);
  assign dout  = mem[rd_ptr[fifo_addr_bits-1:0]];

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr[fifo_addr_bits-1:0]] <= din;
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  no_overflow_a: assert property (@(posedge aclk) disable iff (!arstn) push |-> !full);
  no_underflow_a: assert property (@(posedge aclk) disable iff (!arstn) pop |-> !empty);

endmodule

// File: lcd_regs.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// full FIFO stalls the write ack
// window write wins over window read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lcd_regs (
  input  logic                     aclk,
  input  logic                     arstn,
  input  logic                     reg_wr_en,
  input  lcd_bus_pkg::reg_addr_t   reg_wr_addr,
  input  lcd_bus_pkg::axil_data_t  reg_wr_data,
  output logic                     reg_wr_ack,
  input  logic                     reg_rd_en,
  input  lcd_bus_pkg::reg_addr_t   reg_rd_addr,
  output lcd_bus_pkg::axil_data_t  reg_rd_data,
  output logic                     reg_rd_ack,
  input  logic                     cmd_full,
  input  logic                     data_full,
  input  logic                     cmd_empty,
  input  logic                     data_empty,
  output logic                     cmd_push,
  output logic                     data_push,
  output logic                     win_wr_req,
  output logic                     win_rd_req,
  input  logic                     win_ack,
  input  lcd_bus_pkg::bus_word_t   win_rd_data,
  output lcd_bus_pkg::timing_cfg_t timing,
  output logic                     rst_n,
  output logic                     cs_n
);
  import lcd_bus_pkg::*;

  reg_addr_t wr_ofs;
  reg_addr_t rd_ofs;
  logic      wr_win;
  logic      rd_win;
  logic      wr_lock;
  logic      rd_lock;

  assign wr_ofs     = {reg_wr_addr[7:2], 2'b00};
  assign rd_ofs     = {reg_rd_addr[7:2], 2'b00};
  assign wr_win     = reg_wr_en && (wr_ofs == reg_window);
  assign rd_win     = reg_rd_en && (rd_ofs == reg_window);
  assign win_wr_req = wr_lock;
  assign win_rd_req = rd_lock;
  assign cmd_push   = reg_wr_en && (wr_ofs == reg_cmd_fifo) && !cmd_full;
  assign data_push  = reg_wr_en && (wr_ofs == reg_data_fifo) && !data_full;

  always_comb begin
    reg_wr_ack = 1'b0;
    if (reg_wr_en) begin
      case (wr_ofs)
        reg_window:    reg_wr_ack = win_ack & wr_lock;
        reg_cmd_fifo:  reg_wr_ack = ~cmd_full;
        reg_data_fifo: reg_wr_ack = ~data_full;
        default:       reg_wr_ack = 1'b1;  // includes unmapped
      endcase
    end
  end

  always_comb begin
    reg_rd_ack  = rd_win ? (win_ack & rd_lock) : reg_rd_en;
    reg_rd_data = '0;
    case (rd_ofs)
      reg_version: reg_rd_data = version_value;
      reg_timing:  reg_rd_data = timing;
      reg_control: reg_rd_data[4] = rst_n;
      reg_window:  reg_rd_data[15:0] = win_rd_data;
      reg_csn:     reg_rd_data[0] = cs_n;
      reg_status:  reg_rd_data[3:0] = {data_full, data_empty, cmd_full, cmd_empty};
      default:     reg_rd_data = '0;
    endcase
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      timing  <= '0;
      rst_n   <= 1'b0;
      cs_n    <= 1'b1;
      wr_lock <= 1'b0;
      rd_lock <= 1'b0;
    end else begin
      if (reg_wr_en && wr_ofs == reg_timing) timing <= timing_cfg_t'(reg_wr_data);
      if (reg_wr_en && wr_ofs == reg_control) rst_n <= reg_wr_data[4];
      if (reg_wr_en && wr_ofs == reg_csn) cs_n <= reg_wr_data[0];
      if (win_ack) begin
        wr_lock <= 1'b0;
        rd_lock <= 1'b0;
      end else if (!wr_lock && !rd_lock) begin
        wr_lock <= wr_win;
        rd_lock <= rd_win & ~wr_win;
      end
    end
  end

endmodule

// File: tb_lcd_ctrl.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs with fifo depth 4 and stops at the first error
// din only changes while rd_n is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_lcd_ctrl;
  import lcd_bus_pkg::*;

  typedef logic [16:0] beat_t;  // {dc, dout}

  localparam int clk_period    = 20;
  localparam int max_beats     = 64;
  localparam int max_len       = 20;
  localparam int beat_cycles   = 2 * (max_len + 1) + 10;  // plus AXI overhead
  localparam int margin_cycles = 1000;

  logic       aclk;
  logic       arstn;
  reg_addr_t  awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  reg_addr_t  araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  logic       rst_n;
  logic       cs_n;
  logic       dc;
  logic       wr_n;
  logic       rd_n;
  logic       oe;
  bus_word_t  dout;
  bus_word_t  din;

  integer     seed = 32'h89c7_4d44;
  beat_t      exp_q[$];
  beat_t      got_q[$];
  int         width_q[$];
  int         low_cnt = 0;
  int         cur_wr_low = 0;
  bus_word_t  rd_sample;
  beat_t      got_beat;
  beat_t      exp_beat;
  int         got_width;

  lcd_ctrl_top #(.fifo_addr_bits(2)) i_lcd_ctrl_top (
    .aclk(aclk), .arstn(arstn),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .rst_n(rst_n), .cs_n(cs_n), .dc(dc), .wr_n(wr_n), .rd_n(rd_n),
    .oe(oe), .dout(dout), .din(din)
  );

  always #(clk_period / 2) aclk = ~aclk;

  function automatic axil_data_t rand32();
    return axil_data_t'($random(seed));
  endfunction

  function automatic axil_data_t make_cmd(input cmd_op_t op, input logic [23:0] arg);
    cmd_word_t cw;
    cw.op     = op;
    cw.unused = '0;
    cw.arg    = arg;
    return axil_data_t'(cw);
  endfunction

  // expected beats of a command list, appended to exp_q
  function automatic void expand_cmds(input axil_data_t cmds[$], input axil_data_t data[$]);
    axil_data_t w;
    int         n;
    int         k;
    int         i;
    int         di;
    di = 0;
    for (i = 0; i < cmds.size(); i++) begin
      w = cmds[i];
      case (cmd_op_t'(w[31:30]))
        op_write_cmd:   exp_q.push_back({1'b0, w[15:0]});
        op_write_param: exp_q.push_back({1'b1, w[15:0]});
        op_write_n_param: begin
          n = (int'(w[23:0]) + 1) / 2;
          if (n == 0) n = 1;
          for (k = 0; k < n; k++) begin
            if (k % 2 == 0) exp_q.push_back({1'b1, data[di][15:0]});
            else exp_q.push_back({1'b1, data[di][31:16]});
            if (k % 2 == 1 || k == n - 1) di++;  // next data word
          end
        end
        default: ;  // reserved, no beat
      endcase
    end
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input axil_data_t exp, input axil_data_t got);
    if (exp !== got) fail_now($sformatf("error %s exp %h got %h", name, exp, got));
  endtask

  task automatic check_beat(input logic exp_dc, input bus_word_t exp_word,
                            input logic got_dc, input bus_word_t got_word);
    if (exp_dc !== got_dc || exp_word !== got_word) begin
      fail_now($sformatf("error dc/dout exp %h/%h got %h/%h",
                         exp_dc, exp_word, got_dc, got_word));
    end
  endtask

  task automatic check_width(input int exp, input int got);
    if (exp != got) fail_now($sformatf("error wr_n low width exp %h got %h", exp, got));
  endtask

  task automatic axi_write(input reg_addr_t addr, input axil_data_t data);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge aclk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    while (!aw_done || !w_done) begin
      @(negedge aclk);
      if (awready) aw_done = 1'b1;
      if (wready) w_done = 1'b1;
      @(posedge aclk);
      if (aw_done) awvalid <= 1'b0;
      if (w_done) wvalid <= 1'b0;
    end
    do @(negedge aclk); while (!bvalid);
    check_data("bresp", {30'h0, axi_resp_okay}, {30'h0, bresp});
  endtask

  task automatic axi_read(input reg_addr_t addr, output axil_data_t data);
    @(posedge aclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(negedge aclk); while (!arready);
    @(posedge aclk);
    arvalid <= 1'b0;
    do @(negedge aclk); while (!rvalid);
    data = rdata;
    check_data("rresp", {30'h0, axi_resp_okay}, {30'h0, rresp});
  endtask

  task automatic set_timing(input logic [7:0] wl, input logic [7:0] wh,
                            input logic [7:0] rl, input logic [7:0] rh);
    timing_cfg_t t;
    t.wr_low_len  = wl;
    t.wr_high_len = wh;
    t.rd_low_len  = rl;
    t.rd_high_len = rh;
    cur_wr_low    = int'(wl);
    axi_write(reg_timing, axil_data_t'(t));
  endtask

  task automatic set_random_timing();
    axil_data_t r;
    r = rand32() & 32'h0707_0707;  // lengths 0..7
    set_timing(r[7:0], r[15:8], r[23:16], r[31:24]);
  endtask

  task automatic wait_drain();
    do @(negedge aclk); while (exp_q.size() != 0 || oe);
  endtask

  // display model
  initial begin
    din = '0;
    forever begin
      @(posedge aclk);
      if (rd_n) din <= 16'(rand32());
    end
  end

  always @(negedge aclk) begin
    if (!wr_n) begin
      low_cnt++;
    end else if (low_cnt != 0) begin
      got_q.push_back({dc, dout});  // wr_n just rose
      width_q.push_back(low_cnt);
      low_cnt = 0;
    end
    if (!rd_n) rd_sample = din;
  end

  always @(negedge aclk) begin
    if (got_q.size() != 0) begin
      got_beat  = got_q.pop_front();
      got_width = width_q.pop_front();
      if (exp_q.size() == 0) begin
        fail_now("a beat appeared on the display bus while none was expected");
      end else begin
        exp_beat = exp_q.pop_front();
        check_beat(exp_beat[16], exp_beat[15:0], got_beat[16], got_beat[15:0]);
        check_width(cur_wr_low + 1, got_width);
      end
    end
  end

  initial begin
    #((max_beats * beat_cycles + margin_cycles) * clk_period);
    fail_now("the run timed out before all bus traffic finished");
  end

  initial begin
    axil_data_t  r;
    axil_data_t  w;
    axil_data_t  cq[$];
    axil_data_t  dq[$];
    logic [23:0] cnt;
    int          nb;
    int          nw;
    int          i;
    int          k;
    aclk    = 1'b0;
    arstn   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    repeat (5) @(posedge aclk);
    arstn <= 1'b1;
    @(negedge aclk);

    check_data("rst_n", 32'h0, {31'h0, rst_n});
    check_data("cs_n", 32'h1, {31'h0, cs_n});
    check_data("wr_n", 32'h1, {31'h0, wr_n});
    check_data("rd_n", 32'h1, {31'h0, rd_n});
    check_data("oe", 32'h0, {31'h0, oe});
    axi_read(reg_version, r);
    check_data("version", version_value, r);
    w = rand32();
    axi_write(reg_timing, w);
    axi_read(reg_timing, r);
    check_data("timing", w, r);
    axi_read(reg_status, r);
    check_data("status", 32'h5, r);  // both FIFOs empty
    axi_write(reg_control, 32'h10);  // release panel reset
    axi_write(reg_csn, 32'h0);
    check_data("rst_n", 32'h1, {31'h0, rst_n});
    check_data("cs_n", 32'h0, {31'h0, cs_n});

    for (i = 0; i < 4; i++) begin
      set_random_timing();
      w = rand32();
      exp_q.push_back({w[31], w[15:0]});
      axi_write(reg_window, w);
      wait_drain();
    end

    set_random_timing();
    cq.delete();
    dq.delete();
    for (i = 0; i < 12; i++) begin
      w = rand32();
      if (w[31:30] == 2'd2) w[31:30] = 2'd3;  // no write_n_param here
      cq.push_back(w);
    end
    expand_cmds(cq, dq);
    for (i = 0; i < 12; i++) axi_write(reg_cmd_fifo, cq[i]);
    wait_drain();

    for (i = 0; i < 3; i++) begin
      set_random_timing();
      cnt = 24'(rand32() % 32'd17);
      nb  = (int'(cnt) + 1) / 2;
      if (nb == 0) nb = 1;
      nw = (nb + 1) / 2;
      cq.delete();
      dq.delete();
      cq.push_back(make_cmd(op_write_n_param, cnt));
      for (k = 0; k < nw; k++) dq.push_back(rand32());
      expand_cmds(cq, dq);
      axi_write(reg_cmd_fifo, cq[0]);
      for (k = 0; k < nw; k++) axi_write(reg_data_fifo, dq[k]);
      wait_drain();
    end

    for (i = 0; i < 3; i++) begin
      set_random_timing();
      axi_read(reg_window, r);
      check_data("window rdata", {16'h0, rd_sample}, r);
    end

    set_timing(8'd20, 8'd20, 8'd0, 8'd0);  // slow beats let the FIFOs fill
    cq.delete();
    dq.delete();
    cq.push_back(make_cmd(op_write_n_param, 24'd24));  // 12 beats from 6 words
    for (k = 0; k < 4; k++) begin
      w = rand32();
      cq.push_back(make_cmd(op_write_cmd, w[23:0]));
    end
    for (k = 0; k < 6; k++) dq.push_back(rand32());
    expand_cmds(cq, dq);
    axi_write(reg_cmd_fifo, cq[0]);
    do axi_read(reg_status, r); while (!r[0]);  // engine holds it in wait_data
    for (k = 1; k < 5; k++) axi_write(reg_cmd_fifo, cq[k]);
    axi_read(reg_status, r);
    check_data("status", 32'h6, r);  // cmd full
    for (k = 0; k < 5; k++) axi_write(reg_data_fifo, dq[k]);
    fork
      axi_write(reg_data_fifo, dq[5]);
      begin
        repeat (8) begin
          @(negedge aclk);
          check_data("bvalid", 32'h0, {31'h0, bvalid});
        end
        axi_read(reg_status, r);
        check_data("status", 32'ha, r);  // data and cmd full
      end
    join
    wait_drain();

    if (got_q.size() != 0) fail_now("some bus beats were never compared");
    $display("All tests passed!");
    $finish;
  end

endmodule
